// ==== Bender.yml ====
package:
  name: compute_core

sources:
  - gpu_pkg.sv
  - scalar_alu.sv
  - warp_reg_file.sv
  - instr_decoder.sv
  - instr_fetcher.sv
  - load_store_unit.sv
  - warp_scheduler.sv
  - compute_core.sv
  - target: simulation
    files:
      - compute_core_assert.sv
      - tb_compute_core.sv

// ==== build.f ====
gpu_pkg.sv
scalar_alu.sv
warp_reg_file.sv
instr_decoder.sv
instr_fetcher.sv
load_store_unit.sv
warp_scheduler.sv
compute_core.sv
compute_core_assert.sv
tb_compute_core.sv

// ==== compute_core.sv ====
`timescale 1ns/1ps

module compute_core #(
    parameter int WARPS = 4,
    parameter int ADDR_WIDTH = 16,
    localparam int WARP_BITS = (WARPS > 1) ? $clog2(WARPS) : 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  logic [$clog2(WARPS+1)-1:0] num_warps,
    input  logic [ADDR_WIDTH-1:0]      base_pc,
    output logic                       done,
    // wishbone classic instruction bus
    output logic                       ibus_cyc,
    output logic                       ibus_stb,
    output logic [ADDR_WIDTH-1:0]      ibus_adr,
    input  gpu_pkg::word_t             ibus_rdata,
    input  logic                       ibus_ack,
    // wishbone classic data bus
    output logic                       dbus_cyc,
    output logic                       dbus_stb,
    output logic                       dbus_we,
    output logic [ADDR_WIDTH-1:0]      dbus_adr,
    output gpu_pkg::word_t             dbus_wdata,
    input  gpu_pkg::word_t             dbus_rdata,
    input  logic                       dbus_ack
);

    // scheduler handshakes
    logic                  fetch_start;
    logic                  fetch_done;
    logic [ADDR_WIDTH-1:0] fetch_pc;
    logic [WARP_BITS-1:0]  cur_warp;
    logic                  retire;
    logic                  mem_start;
    logic                  mem_done;

    // decoded fields
    gpu_pkg::instr_t    instr;
    gpu_pkg::opcode_e   opcode;
    gpu_pkg::reg_addr_t rd;
    gpu_pkg::reg_addr_t rs1;
    gpu_pkg::reg_addr_t rs2;
    gpu_pkg::word_t     imm;
    logic               reg_write;
    logic               is_mem;
    logic               is_load;
    logic               is_halt;

    // datapath
    gpu_pkg::word_t rs1_data;
    gpu_pkg::word_t rs2_data;
    gpu_pkg::word_t alu_result;
    gpu_pkg::word_t load_data;
    logic           branch_taken;
    logic           write_en;

    // write back only when the instruction completes
    assign write_en = retire & reg_write;

    warp_scheduler #(
        .WARPS      (WARPS),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_warp_scheduler (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .num_warps    (num_warps),
        .base_pc      (base_pc),
        .fetch_done   (fetch_done),
        .mem_done     (mem_done),
        .is_mem       (is_mem),
        .is_halt      (is_halt),
        .branch_taken (branch_taken),
        .imm          (imm),
        .fetch_start  (fetch_start),
        .fetch_pc     (fetch_pc),
        .cur_warp     (cur_warp),
        .retire       (retire),
        .mem_start    (mem_start),
        .done         (done)
    );

    instr_fetcher #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_instr_fetcher (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc),
        .ibus_rdata  (ibus_rdata),
        .ibus_ack    (ibus_ack),
        .ibus_cyc    (ibus_cyc),
        .ibus_stb    (ibus_stb),
        .ibus_adr    (ibus_adr),
        .fetch_done  (fetch_done),
        .instr       (instr)
    );

    instr_decoder u_instr_decoder (
        .instr     (instr),
        .opcode    (opcode),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .reg_write (reg_write),
        .is_mem    (is_mem),
        .is_load   (is_load),
        .is_halt   (is_halt),
        .is_branch ()
    );

    warp_reg_file #(
        .WARPS (WARPS)
    ) u_warp_reg_file (
        .clk        (clk),
        .reset      (reset),
        .cur_warp   (cur_warp),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .write_en   (write_en),
        .is_load    (is_load),
        .alu_result (alu_result),
        .load_data  (load_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    scalar_alu #(
        .WARPS (WARPS)
    ) u_scalar_alu (
        .opcode       (opcode),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .cur_warp     (cur_warp),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    load_store_unit #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_load_store_unit (
        .clk        (clk),
        .reset      (reset),
        .mem_start  (mem_start),
        .is_load    (is_load),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_wdata (dbus_wdata),
        .mem_done   (mem_done),
        .load_data  (load_data)
    );

endmodule

// ==== compute_core_assert.sv ====
`timescale 1ns/1ps

module compute_core_assert #(
    parameter int ADDR_WIDTH = 16
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  start,
    input logic                  done,
    input logic                  fetch_start,
    input logic                  mem_start,
    input logic                  retire,
    input logic                  ibus_cyc,
    input logic                  ibus_stb,
    input logic [ADDR_WIDTH-1:0] ibus_adr,
    input logic                  ibus_ack,
    input logic                  dbus_cyc,
    input logic                  dbus_stb,
    input logic                  dbus_we,
    input logic [ADDR_WIDTH-1:0] dbus_adr,
    input gpu_pkg::word_t        dbus_wdata,
    input logic                  dbus_ack
);

    int   fail_count = 0;
    logic started;

    // set by the first start after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    // quiet buses and no done before the first start
    assert property (@(posedge clk) disable iff (reset)
        !started |-> !(ibus_cyc || ibus_stb || dbus_cyc || dbus_stb || dbus_we || done))
    else begin
        $error("bus or done active before start");
        fail_count++;
    end

    // stalled ibus request holds
    assert property (@(posedge clk) disable iff (reset)
        (ibus_stb && !ibus_ack) |=> (ibus_stb && ibus_cyc && $stable(ibus_adr)))
    else begin
        $error("ibus request changed while stalled");
        fail_count++;
    end

    // stalled dbus request holds, write data too
    assert property (@(posedge clk) disable iff (reset)
        (dbus_stb && !dbus_ack) |=> (dbus_stb && dbus_cyc && $stable(dbus_adr) &&
                                     $stable(dbus_we) && $stable(dbus_wdata)))
    else begin
        $error("dbus request changed while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset) (ibus_stb |-> ibus_cyc) and
                     (dbus_stb |-> dbus_cyc))
    else begin
        $error("stb high without cyc");
        fail_count++;
    end

    // cycle ends right after the ack edge
    assert property (@(posedge clk) disable iff (reset)
        ((ibus_cyc && ibus_ack) |=> !ibus_cyc) and ((dbus_cyc && dbus_ack) |=> !dbus_cyc))
    else begin
        $error("cyc still high after ack");
        fail_count++;
    end

    // request pulses open a bus cycle on the next edge
    assert property (@(posedge clk) disable iff (reset)
        (fetch_start |=> (ibus_cyc && ibus_stb)) and (mem_start |=> (dbus_cyc && dbus_stb)))
    else begin
        $error("request pulse did not start a bus cycle");
        fail_count++;
    end

    // retire leads to the next fetch or to done
    assert property (@(posedge clk) disable iff (reset) retire |=> (fetch_start || done))
    else begin
        $error("retire followed by neither fetch nor done");
        fail_count++;
    end

endmodule

bind compute_core compute_core_assert #(
    .ADDR_WIDTH (ADDR_WIDTH)
) u_compute_core_assert (.*);

// ==== gpu_pkg.sv ====
package gpu_pkg;

    // one data word on the data bus and in the register file
    typedef logic [31:0] word_t;

    // register index, four bits wide
    typedef logic [3:0] reg_addr_t;

    // r0 reads as zero
    localparam int NUM_REGS = 16;

    // 4-bit opcode, codes 12 to 14 are unused and run as nop
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SLT  = 4'd6,
        ADDI = 4'd7,
        WID  = 4'd8,
        LW   = 4'd9,
        SW   = 4'd10,
        BNZ  = 4'd11,
        HALT = 4'd15
    } opcode_e;

    // fixed 32-bit instruction format
    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [15:0] imm;
    } instr_t;

    // per-warp state
    typedef enum logic [2:0] {
        WARP_IDLE  = 3'd0,
        WARP_READY = 3'd1,
        WARP_DONE  = 3'd2
    } warp_state_e;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  gpu_pkg::instr_t    instr,
    output gpu_pkg::opcode_e   opcode,
    output gpu_pkg::reg_addr_t rd,
    output gpu_pkg::reg_addr_t rs1,
    output gpu_pkg::reg_addr_t rs2,
    output gpu_pkg::word_t     imm,
    output logic               reg_write,
    output logic               is_mem,
    output logic               is_load,
    output logic               is_halt,
    output logic               is_branch
);

    assign rd  = instr.rd;
    assign rs1 = instr.rs1;
    assign rs2 = instr.rs2;

    // sign extend the 16-bit immediate
    assign imm = {{16{instr.imm[15]}}, instr.imm};

    always_comb begin
        case (instr.opcode)
            gpu_pkg::ADD, gpu_pkg::SUB, gpu_pkg::AND, gpu_pkg::OR, gpu_pkg::XOR,
            gpu_pkg::SLT, gpu_pkg::ADDI, gpu_pkg::WID, gpu_pkg::LW, gpu_pkg::SW,
            gpu_pkg::BNZ, gpu_pkg::HALT: opcode = instr.opcode;
            // unused codes run as nop
            default: opcode = gpu_pkg::NOP;
        endcase
    end

    // everything up to wid writes rd, plus loads
    assign reg_write = (opcode inside {[gpu_pkg::ADD:gpu_pkg::WID]}) || (opcode == gpu_pkg::LW);
    assign is_mem    = (opcode == gpu_pkg::LW) || (opcode == gpu_pkg::SW);
    assign is_load   = (opcode == gpu_pkg::LW);
    assign is_halt   = (opcode == gpu_pkg::HALT);
    assign is_branch = (opcode == gpu_pkg::BNZ);

endmodule

// ==== instr_fetcher.sv ====
`timescale 1ns/1ps

module instr_fetcher #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_start,
    input  logic [ADDR_WIDTH-1:0] fetch_pc,
    input  gpu_pkg::word_t        ibus_rdata,
    input  logic                  ibus_ack,
    output logic                  ibus_cyc,
    output logic                  ibus_stb,
    output logic [ADDR_WIDTH-1:0] ibus_adr,
    output logic                  fetch_done,
    output gpu_pkg::instr_t       instr
);

    // one read cycle per fetch_start
    always_ff @(posedge clk) begin
        if (reset) begin
            ibus_cyc   <= 1'b0;
            ibus_stb   <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (ibus_cyc && ibus_ack) begin
                // ack seen, release the bus
                ibus_cyc   <= 1'b0;
                ibus_stb   <= 1'b0;
                fetch_done <= 1'b1;
            end else if (fetch_start) begin
                ibus_cyc <= 1'b1;
                ibus_stb <= 1'b1;
            end
        end
    end

    // address held for the whole cycle, word held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch_start && !ibus_cyc) begin
            ibus_adr <= fetch_pc;
        end
        if (ibus_cyc && ibus_ack) begin
            instr <= gpu_pkg::instr_t'(ibus_rdata);
        end
    end

endmodule

// ==== load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_start,
    input  logic                  is_load,
    input  gpu_pkg::word_t        addr,
    input  gpu_pkg::word_t        store_data,
    input  gpu_pkg::word_t        dbus_rdata,
    input  logic                  dbus_ack,
    output logic                  dbus_cyc,
    output logic                  dbus_stb,
    output logic                  dbus_we,
    output logic [ADDR_WIDTH-1:0] dbus_adr,
    output gpu_pkg::word_t        dbus_wdata,
    output logic                  mem_done,
    output gpu_pkg::word_t        load_data
);

    // one read or write per mem_start
    always_ff @(posedge clk) begin
        if (reset) begin
            dbus_cyc <= 1'b0;
            dbus_stb <= 1'b0;
            dbus_we  <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (dbus_cyc && dbus_ack) begin
                // ack seen, end the cycle
                dbus_cyc <= 1'b0;
                dbus_stb <= 1'b0;
                dbus_we  <= 1'b0;
                mem_done <= 1'b1;
            end else if (mem_start) begin
                dbus_cyc <= 1'b1;
                dbus_stb <= 1'b1;
                dbus_we  <= !is_load;
            end
        end
    end

    // word address and store data, captured once per request
    always_ff @(posedge clk) begin
        if (mem_start && !dbus_cyc) begin
            dbus_adr   <= addr[ADDR_WIDTH-1:0];
            dbus_wdata <= store_data;
        end
        // read word taken on the ack edge
        if (dbus_cyc && dbus_ack && !dbus_we) begin
            load_data <= dbus_rdata;
        end
    end

endmodule

// ==== scalar_alu.sv ====
`timescale 1ns/1ps

module scalar_alu #(
    parameter int WARPS = 4,
    localparam int WARP_BITS = (WARPS > 1) ? $clog2(WARPS) : 1
) (
    input  gpu_pkg::opcode_e     opcode,
    input  gpu_pkg::word_t       rs1_data,
    input  gpu_pkg::word_t       rs2_data,
    input  gpu_pkg::word_t       imm,
    input  logic [WARP_BITS-1:0] cur_warp,
    output gpu_pkg::word_t       alu_result,
    output logic                 branch_taken
);

    always_comb begin
        case (opcode)
            gpu_pkg::ADD: alu_result = rs1_data + rs2_data;
            gpu_pkg::SUB: alu_result = rs1_data - rs2_data;
            gpu_pkg::AND: alu_result = rs1_data & rs2_data;
            gpu_pkg::OR:  alu_result = rs1_data | rs2_data;
            gpu_pkg::XOR: alu_result = rs1_data ^ rs2_data;
            // signed compare, 1 or 0
            gpu_pkg::SLT: alu_result = ($signed(rs1_data) < $signed(rs2_data)) ? 32'd1 : 32'd0;
            // addi result, also the effective address of lw and sw
            gpu_pkg::ADDI, gpu_pkg::LW, gpu_pkg::SW: alu_result = rs1_data + imm;
            gpu_pkg::WID: alu_result = gpu_pkg::word_t'(cur_warp);
            default: alu_result = '0;
        endcase
    end

    // bnz tests rs1 only
    assign branch_taken = (opcode == gpu_pkg::BNZ) && (rs1_data != '0);

endmodule

// ==== tb_compute_core.sv ====
`timescale 1ns/1ps

module tb_compute_core;

    localparam int WARPS = 4;
    localparam int ADDR_WIDTH = 16;
    // generous bound on cycles per program run
    localparam int DONE_TIMEOUT = 20000;
    localparam int DATA_BASE = 'h100;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  start;
    logic [2:0]            num_warps;
    logic [ADDR_WIDTH-1:0] base_pc;
    logic                  done;
    logic                  ibus_cyc;
    logic                  ibus_stb;
    logic [ADDR_WIDTH-1:0] ibus_adr;
    gpu_pkg::word_t        ibus_rdata;
    logic                  ibus_ack;
    logic                  dbus_cyc;
    logic                  dbus_stb;
    logic                  dbus_we;
    logic [ADDR_WIDTH-1:0] dbus_adr;
    gpu_pkg::word_t        dbus_wdata;
    gpu_pkg::word_t        dbus_rdata;
    logic                  dbus_ack;

    // bus memories
    gpu_pkg::word_t rom [256];
    gpu_pkg::word_t ram [1024];

    // expected store stream with one list per warp
    logic [ADDR_WIDTH-1:0] exp_adr [WARPS][16];
    gpu_pkg::word_t        exp_dat [WARPS][16];
    int                    exp_cnt [WARPS];
    int                    got_cnt [WARPS];

    int          check_errors = 0;
    int          active_warps = 0;
    int          prog_pc;
    int          i_wait;
    int          d_wait;
    logic        timed_out = 1'b0;
    logic [31:0] rng = 32'h2035bcc1;

    compute_core #(
        .WARPS      (WARPS),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_compute_core (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .num_warps  (num_warps),
        .base_pc    (base_pc),
        .done       (done),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // opcode rd rs1 rs2 imm16
    function automatic gpu_pkg::word_t encode(input logic [3:0] op, input int rd,
                                              input int rs1, input int rs2, input int imm);
        return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    endfunction

    // word preset for each warp's load
    function automatic gpu_pkg::word_t preset_word(input int w);
        return 32'h0c00_0000 + 32'h111 * (w + 1);
    endfunction

    task automatic emit(input gpu_pkg::word_t word);
        rom[prog_pc[7:0]] = word;
        prog_pc++;
    endtask

    task automatic load_program(input logic [ADDR_WIDTH-1:0] base);
        int loop_pc;
        prog_pc = int'(base);
        // operands from the warp index
        emit(encode(gpu_pkg::WID, 1, 0, 0, 0));
        emit(encode(gpu_pkg::ADDI, 2, 1, 0, 5));
        emit(encode(gpu_pkg::ADDI, 3, 1, 0, -3));
        // r4 doubles up to 16 * warp and then adds the data block base
        emit(encode(gpu_pkg::ADD, 4, 1, 1, 0));
        emit(encode(gpu_pkg::ADD, 4, 4, 4, 0));
        emit(encode(gpu_pkg::ADD, 4, 4, 4, 0));
        emit(encode(gpu_pkg::ADD, 4, 4, 4, 0));
        emit(encode(gpu_pkg::ADDI, 4, 4, 0, DATA_BASE));
        emit(encode(gpu_pkg::ADD, 5, 2, 3, 0));
        emit(encode(gpu_pkg::SUB, 6, 3, 2, 0));
        emit(encode(gpu_pkg::AND, 7, 2, 3, 0));
        emit(encode(gpu_pkg::OR, 8, 2, 3, 0));
        emit(encode(gpu_pkg::XOR, 9, 2, 3, 0));
        emit(encode(gpu_pkg::SLT, 10, 3, 2, 0));
        emit(encode(gpu_pkg::SLT, 11, 2, 3, 0));
        emit(encode(gpu_pkg::NOP, 0, 0, 0, 0));
        // unused code 12 aimed at r1 must not write
        emit(encode(4'd12, 1, 1, 1, 7));
        emit(encode(gpu_pkg::SW, 0, 4, 1, 0));
        emit(encode(gpu_pkg::SW, 0, 4, 5, 1));
        emit(encode(gpu_pkg::SW, 0, 4, 6, 2));
        emit(encode(gpu_pkg::SW, 0, 4, 7, 3));
        emit(encode(gpu_pkg::SW, 0, 4, 8, 4));
        emit(encode(gpu_pkg::SW, 0, 4, 9, 5));
        emit(encode(gpu_pkg::SW, 0, 4, 10, 6));
        emit(encode(gpu_pkg::SW, 0, 4, 11, 7));
        // load round trip
        emit(encode(gpu_pkg::LW, 12, 4, 0, 15));
        emit(encode(gpu_pkg::ADDI, 12, 12, 0, 100));
        emit(encode(gpu_pkg::SW, 0, 4, 12, 8));
        // countdown loop from 3 + warp
        emit(encode(gpu_pkg::ADDI, 13, 1, 0, 3));
        loop_pc = prog_pc;
        emit(encode(gpu_pkg::SW, 0, 4, 13, 9));
        emit(encode(gpu_pkg::ADDI, 13, 13, 0, -1));
        emit(encode(gpu_pkg::BNZ, 0, 13, 0, loop_pc - prog_pc));
        emit(encode(gpu_pkg::HALT, 0, 0, 0, 0));
    endtask

    task automatic add_expected(input int w, input int offset, input gpu_pkg::word_t data);
        exp_adr[w][exp_cnt[w]] = ADDR_WIDTH'(DATA_BASE + 16 * w + offset);
        exp_dat[w][exp_cnt[w]] = data;
        exp_cnt[w]++;
    endtask

    task automatic build_expected(input int active);
        int r2;
        int r3;
        for (int w = 0; w < WARPS; w++) begin
            exp_cnt[w] = 0;
            got_cnt[w] = 0;
            ram[DATA_BASE + 16 * w + 15] = preset_word(w);
        end
        for (int w = 0; w < active; w++) begin
            r2 = w + 5;
            r3 = w - 3;
            add_expected(w, 0, w);
            add_expected(w, 1, r2 + r3);
            add_expected(w, 2, r3 - r2);
            add_expected(w, 3, r2 & r3);
            add_expected(w, 4, r2 | r3);
            add_expected(w, 5, r2 ^ r3);
            // signed compares
            add_expected(w, 6, (r3 < r2) ? 1 : 0);
            add_expected(w, 7, (r2 < r3) ? 1 : 0);
            add_expected(w, 8, preset_word(w) + 100);
            for (int c = 3 + w; c > 0; c--) begin
                add_expected(w, 9, c);
            end
        end
    endtask

    task automatic check_store(input logic [ADDR_WIDTH-1:0] adr, input gpu_pkg::word_t data);
        logic in_range;
        int   w;
        int   k;
        in_range = (adr >= DATA_BASE) && (adr < DATA_BASE + 16 * active_warps);
        assert (in_range) else begin
            $display("store at %0t to address %h outside every active warp block", $time, adr);
            check_errors++;
        end
        if (in_range) begin
            w = (int'(adr) - DATA_BASE) / 16;
            k = got_cnt[w];
            assert (k < exp_cnt[w]) else begin
                $display("warp %0d made more stores than expected at %0t", w, $time);
                check_errors++;
            end
            if (k < exp_cnt[w]) begin
                assert (adr == exp_adr[w][k]) else begin
                    $display("[FAIL] %0t dbus_adr expected %h actual %h",
                             $time, exp_adr[w][k], adr);
                    check_errors++;
                end
                assert (data == exp_dat[w][k]) else begin
                    $display("[FAIL] %0t dbus_wdata expected %h actual %h",
                             $time, exp_dat[w][k], data);
                    check_errors++;
                end
            end
            got_cnt[w]++;
        end
    endtask

    // both slaves in one process with ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (reset) begin
            ibus_ack = 1'b0;
            dbus_ack = 1'b0;
            i_wait = -1;
            d_wait = -1;
        end else begin
            if (ibus_ack) begin
                ibus_ack = 1'b0;
                i_wait = -1;
            end else if (ibus_cyc && ibus_stb) begin
                if (i_wait < 0) begin
                    rng = xorshift32(rng);
                    i_wait = int'(rng[1:0]);
                end
                if (i_wait == 0) begin
                    ibus_rdata = rom[ibus_adr[7:0]];
                    ibus_ack = 1'b1;
                end else begin
                    i_wait--;
                end
            end
            if (dbus_ack) begin
                dbus_ack = 1'b0;
                d_wait = -1;
            end else if (dbus_cyc && dbus_stb) begin
                if (d_wait < 0) begin
                    rng = xorshift32(rng);
                    d_wait = int'(rng[1:0]);
                end
                if (d_wait == 0) begin
                    if (dbus_we) begin
                        ram[dbus_adr[9:0]] = dbus_wdata;
                        check_store(dbus_adr, dbus_wdata);
                    end else begin
                        dbus_rdata = ram[dbus_adr[9:0]];
                    end
                    dbus_ack = 1'b1;
                end else begin
                    d_wait--;
                end
            end
        end
    end

    task automatic run_program(input int active, input logic [ADDR_WIDTH-1:0] base);
        int cycles;
        load_program(base);
        active_warps = active;
        build_expected(active);
        @(posedge clk);
        #1;
        num_warps = 3'(active);
        base_pc = base;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("timeout, done never rose with %0d warps", active);
            check_errors++;
            timed_out = 1'b1;
        end else begin
            // every halted warp has finished its store stream
            for (int w = 0; w < WARPS; w++) begin
                assert (got_cnt[w] == exp_cnt[w]) else begin
                    $display("[FAIL] %0t store_count[%0d] expected %0d actual %0d",
                             $time, w, exp_cnt[w], got_cnt[w]);
                    check_errors++;
                end
            end
        end
    endtask

    initial begin
        int assert_errors;
        reset = 1'b1;
        start = 1'b0;
        num_warps = '0;
        base_pc = '0;
        ibus_rdata = '0;
        ibus_ack = 1'b0;
        dbus_rdata = '0;
        dbus_ack = 1'b0;
        // fill patterns keyed on the full address
        // rom fill decodes as halt
        for (int i = 0; i < 256; i++) begin
            rom[i] = {4'hF, 12'h000, 16'(i)};
        end
        for (int i = 0; i < 1024; i++) begin
            ram[i] = 32'h5a5a_0000 ^ i;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle gap so the reset state is observed before start
        repeat (3) @(posedge clk);
        run_program(3, 16'h0010);
        if (!timed_out) begin
            run_program(4, 16'h0040);
        end
        assert_errors = u_compute_core.u_compute_core_assert.fail_count;
        $display("errors: %0d value checks, %0d assertion failures",
                 check_errors, assert_errors);
        if (check_errors == 0 && assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== warp_reg_file.sv ====
`timescale 1ns/1ps

module warp_reg_file #(
    parameter int WARPS = 4,
    localparam int WARP_BITS = (WARPS > 1) ? $clog2(WARPS) : 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [WARP_BITS-1:0] cur_warp,
    input  gpu_pkg::reg_addr_t   rs1,
    input  gpu_pkg::reg_addr_t   rs2,
    input  gpu_pkg::reg_addr_t   rd,
    input  logic                 write_en,
    input  logic                 is_load,
    input  gpu_pkg::word_t       alu_result,
    input  gpu_pkg::word_t       load_data,
    output gpu_pkg::word_t       rs1_data,
    output gpu_pkg::word_t       rs2_data
);

    // one bank per warp
    gpu_pkg::word_t regs [WARPS][gpu_pkg::NUM_REGS];

    // r0 is cleared by reset and never written, so it reads zero
    assign rs1_data = regs[cur_warp][rs1];
    assign rs2_data = regs[cur_warp][rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS; w++) begin
                for (int r = 0; r < gpu_pkg::NUM_REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (write_en && rd != '0) begin
            // loads write back the bus word, the rest the alu
            regs[cur_warp][rd] <= is_load ? load_data : alu_result;
        end
    end

endmodule

// ==== warp_scheduler.sv ====
`timescale 1ns/1ps

module warp_scheduler #(
    parameter int WARPS = 4,
    parameter int ADDR_WIDTH = 16,
    localparam int WARP_BITS = (WARPS > 1) ? $clog2(WARPS) : 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  logic [$clog2(WARPS+1)-1:0] num_warps,
    input  logic [ADDR_WIDTH-1:0]      base_pc,
    input  logic                       fetch_done,
    input  logic                       mem_done,
    input  logic                       is_mem,
    input  logic                       is_halt,
    input  logic                       branch_taken,
    input  gpu_pkg::word_t             imm,
    output logic                       fetch_start,
    output logic [ADDR_WIDTH-1:0]      fetch_pc,
    output logic [WARP_BITS-1:0]       cur_warp,
    output logic                       retire,
    output logic                       mem_start,
    output logic                       done
);

    // phase of the single in-flight instruction
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FETCH,
        PH_EXEC,
        PH_MEM
    } phase_e;

    phase_e                phase;
    gpu_pkg::warp_state_e  warp_state [WARPS];
    logic [ADDR_WIDTH-1:0] pc [WARPS];
    logic [ADDR_WIDTH-1:0] next_pc;
    logic [WARP_BITS-1:0]  next_warp;
    logic                  found;

    assign fetch_pc = pc[cur_warp];

    // execute is one cycle, memory ops hand off to the lsu
    assign mem_start = (phase == PH_EXEC) && is_mem;
    assign retire    = ((phase == PH_EXEC) && !is_mem) || ((phase == PH_MEM) && mem_done);

    // taken bnz jumps relative, everything else steps by one
    assign next_pc = branch_taken ? pc[cur_warp] + ADDR_WIDTH'(imm) : pc[cur_warp] + 1'b1;

    // round robin, search starts after cur_warp and ends on it
    always_comb begin
        int idx;
        found     = 1'b0;
        next_warp = cur_warp;
        for (int k = 1; k <= WARPS; k++) begin
            idx = (int'(cur_warp) + k) % WARPS;
            // a halting warp is no longer a candidate
            if (!found && warp_state[idx] == gpu_pkg::WARP_READY &&
                    !(idx == int'(cur_warp) && is_halt)) begin
                found     = 1'b1;
                next_warp = WARP_BITS'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= PH_IDLE;
            cur_warp    <= '0;
            fetch_start <= 1'b0;
            done        <= 1'b0;
            for (int i = 0; i < WARPS; i++) begin
                warp_state[i] <= gpu_pkg::WARP_IDLE;
            end
        end else begin
            fetch_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    // launch warps 0 to num_warps-1 at base_pc
                    if (start) begin
                        for (int i = 0; i < WARPS; i++) begin
                            warp_state[i] <= (i < num_warps) ? gpu_pkg::WARP_READY
                                                             : gpu_pkg::WARP_IDLE;
                            pc[i] <= base_pc;
                        end
                        cur_warp    <= '0;
                        phase       <= PH_FETCH;
                        fetch_start <= 1'b1;
                        done        <= 1'b0;
                    end
                end
                PH_FETCH: begin
                    if (fetch_done) begin
                        phase <= PH_EXEC;
                    end
                end
                PH_EXEC: begin
                    if (is_mem) begin
                        phase <= PH_MEM;
                    end
                end
                default: begin
                    // wait for mem_done, handled by retire below
                end
            endcase

            // completion, update the warp and pick the next one
            if (retire) begin
                if (is_halt) begin
                    warp_state[cur_warp] <= gpu_pkg::WARP_DONE;
                end else begin
                    pc[cur_warp] <= next_pc;
                end
                if (found) begin
                    cur_warp    <= next_warp;
                    phase       <= PH_FETCH;
                    fetch_start <= 1'b1;
                end else begin
                    // nothing ready, block finished
                    done  <= 1'b1;
                    phase <= PH_IDLE;
                end
            end
        end
    end

endmodule
